//--- logic/agen_pkg.sv
/*
 * Shared widths, selector codes and packed payload types for the address
 * generation stage. Every RTL file refers to these by agen_pkg:: names.
 */

package agen_pkg;

    // register file and datapath widths, fixed by the x86 register set
    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int MMX_W     = 64;
    localparam int OPND_W    = 64;
    localparam int IMM_W     = 48;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 3;

    localparam int NUM_REGS  = 8;
    localparam int NUM_SEG   = 6;

    // real-mode style base: segment times 16
    localparam int SEG_SHIFT = 4;

    // string instructions use these two GPRs
    localparam int GPR_ESI = 6;
    localparam int GPR_EDI = 7;

    // operand source selector from the decoder
    typedef enum logic [2:0] {
        SEL_NONE  = 3'd0,
        SEL_REG   = 3'd1,
        SEL_SEG   = 3'd2,
        SEL_MMX   = 3'd3,
        SEL_MODRM = 3'd4,
        SEL_IMM   = 3'd5,
        SEL_MEM   = 3'd6,
        SEL_SYS   = 3'd7
    } operand_sel_e;

    // operand size; codes 4, 6 and 7 are not produced by the decoder
    typedef enum logic [2:0] {
        SIZE_NONE  = 3'd0,
        SIZE_BYTE  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3,
        SIZE_MMX   = 3'd5
    } size_e;

    // segment register index, 6 and 7 read as zero
    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_idx_e;

    // EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI at index 0 to 7
    typedef logic [NUM_REGS-1:0][GPR_W-1:0] gpr_file_t;
    typedef logic [NUM_SEG-1:0][SEG_W-1:0]  seg_file_t;
    typedef logic [NUM_REGS-1:0][MMX_W-1:0] mmx_file_t;

    // one zero-extended sized view per register index
    typedef logic [NUM_REGS-1:0][OPND_W-1:0] reg_views_t;

    // micro-op fields carried through the stage untouched
    typedef struct packed {
        size_e                size;
        logic                 set_d_flag;
        logic                 clear_d_flag;
        logic [REG_IDX_W-1:0] op0_reg;
        logic [REG_IDX_W-1:0] op1_reg;
        logic [3:0]           alu_op;
        logic [2:0]           flag_0;
        logic [2:0]           flag_1;
        logic [1:0]           stack_op;
        logic [31:0]          pc;
        logic                 branch_taken;
        logic [15:0]          opcode;
        logic [IMM_W-1:0]     imm;
    } uop_ctrl_t;

    // payload handed to the memory stage
    typedef struct packed {
        uop_ctrl_t         ctrl;
        logic [OPND_W-1:0] op0;
        logic [OPND_W-1:0] op1;
        logic              op1_is_address;
        logic              to_sys_controller;
    } agen_out_t;

endpackage

//--- logic/reg_size_select.sv
/*
 * Sized register views. For each register index picks the byte, word,
 * dword or MMX view selected by the micro-op size, zero-extended to 64 bits.
 */

`timescale 1ns/100ps

module reg_size_select (
    input  logic                   clk,
    input  agen_pkg::size_e        size,
    input  agen_pkg::gpr_file_t    gpr,
    input  agen_pkg::mmx_file_t    mmx,
    output agen_pkg::reg_views_t   views
);

    logic [agen_pkg::NUM_REGS-1:0][7:0] byte_view;

    // AL..BL at 0-3, AH..BH at 4-7
    always_comb begin
        for (int i = 0; i < agen_pkg::NUM_REGS; i++) begin
            if (i < 4) begin
                byte_view[i] = gpr[i % 4][7:0];
            end else begin
                byte_view[i] = gpr[i % 4][15:8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < agen_pkg::NUM_REGS; i++) begin
            views[i] = '0;
            case (size)
                agen_pkg::SIZE_BYTE:  views[i][7:0] = byte_view[i];
                agen_pkg::SIZE_WORD:  views[i][15:0] = gpr[i][15:0];
                agen_pkg::SIZE_DWORD: views[i][agen_pkg::GPR_W-1:0] = gpr[i];
                agen_pkg::SIZE_MMX:   views[i] = mmx[i];
                default:              views[i] = '0;
            endcase
        end
    end

    // decoder must never hand over an undefined size code
    a_size_legal: assert property (@(posedge clk)
        size inside {agen_pkg::SIZE_NONE, agen_pkg::SIZE_BYTE, agen_pkg::SIZE_WORD,
                     agen_pkg::SIZE_DWORD, agen_pkg::SIZE_MMX})
        else $error("undefined operand size code %0d", size);

endmodule

//--- logic/string_addr.sv
/*
 * String instruction addresses. Destination is ES:EDI, source is DS:ESI
 * unless a segment override is valid. Segment base is the segment times 16.
 */

`timescale 1ns/100ps

module string_addr (
    input  logic                          clk,
    input  agen_pkg::gpr_file_t           gpr,
    input  agen_pkg::seg_file_t           seg,
    input  agen_pkg::seg_idx_e            seg_override,
    input  logic                          seg_override_valid,
    output logic [agen_pkg::ADDR_W-1:0]   src_addr,
    output logic [agen_pkg::ADDR_W-1:0]   dst_addr
);

    localparam int PAD_W = agen_pkg::ADDR_W - agen_pkg::SEG_W;

    logic [agen_pkg::SEG_W-1:0]  src_seg;
    logic [agen_pkg::ADDR_W-1:0] src_base;
    logic [agen_pkg::ADDR_W-1:0] dst_base;

    // override picks any segment, out of range reads zero
    always_comb begin
        src_seg = seg[agen_pkg::SEG_DS];
        if (seg_override_valid) begin
            if (seg_override < agen_pkg::NUM_SEG) begin
                src_seg = seg[seg_override];
            end else begin
                src_seg = '0;
            end
        end
    end

    assign src_base = {{PAD_W{1'b0}}, src_seg} << agen_pkg::SEG_SHIFT;
    assign dst_base = {{PAD_W{1'b0}}, seg[agen_pkg::SEG_ES]} << agen_pkg::SEG_SHIFT;

    // 32-bit adds, carry out dropped
    assign src_addr = src_base + gpr[agen_pkg::GPR_ESI];
    assign dst_addr = dst_base + gpr[agen_pkg::GPR_EDI];

    a_override_legal: assert property (@(posedge clk)
        seg_override_valid |-> (seg_override < agen_pkg::NUM_SEG))
        else $error("segment override index %0d names no segment", seg_override);

endmodule

//--- logic/operand_select.sv
/*
 * Operand multiplexer for one operand slot. Picks a 64-bit value from the
 * sized register views, segments, MMX file, immediate or a string address.
 * Instantiated once for op0 and once for op1.
 */

`timescale 1ns/100ps

module operand_select (
    input  logic                              clk,
    input  agen_pkg::operand_sel_e            sel,
    input  logic [agen_pkg::REG_IDX_W-1:0]    reg_idx,
    input  agen_pkg::reg_views_t              views,
    input  agen_pkg::seg_file_t               seg,
    input  agen_pkg::mmx_file_t               mmx,
    input  logic [agen_pkg::IMM_W-1:0]        imm,
    input  logic [agen_pkg::ADDR_W-1:0]       mem_addr,
    output logic [agen_pkg::OPND_W-1:0]       operand,
    output logic                              is_address
);

    always_comb begin
        operand = '0;
        case (sel)
            agen_pkg::SEL_REG: begin
                operand = views[reg_idx];
            end
            agen_pkg::SEL_SEG: begin
                // only ES..GS exist
                if (reg_idx < agen_pkg::NUM_SEG) begin
                    operand[agen_pkg::SEG_W-1:0] = seg[reg_idx];
                end
            end
            agen_pkg::SEL_MMX: begin
                operand = mmx[reg_idx];
            end
            agen_pkg::SEL_IMM: begin
                operand[agen_pkg::IMM_W-1:0] = imm;
            end
            agen_pkg::SEL_MEM: begin
                operand[agen_pkg::ADDR_W-1:0] = mem_addr;
            end
            // none, mod r/m and sys all give zero
            default: begin
                operand = '0;
            end
        endcase
    end

    // memory stage reads through this operand
    assign is_address = (sel == agen_pkg::SEL_MEM);

    // mod r/m addressing has no datapath here, decoder must not ask for it
    a_no_modrm: assert property (@(posedge clk)
        sel != agen_pkg::SEL_MODRM)
        else $error("mod r/m operand selected, no address calculation present");

endmodule

//--- logic/pipe_stage.sv
/*
 * One-entry valid/ready pipeline register between address generation and
 * the memory stage. Flush empties it and refuses the item offered that cycle.
 */

`timescale 1ns/100ps

module pipe_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  agen_pkg::agen_out_t   in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output agen_pkg::agen_out_t   out_data
);

    logic load;

    // free slot, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // stalled item stays put until taken or flushed
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data)))
        else $error("output changed while stalled");

endmodule

//--- logic/agen_top.sv
/*
 * Address generation stage top level. Builds both operands from the
 * register files and micro-op, then registers them with the control fields
 * in a valid/ready pipe register towards the memory stage.
 */

`timescale 1ns/100ps

module agen_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,

    // from register access
    input  logic                      r_valid,
    output logic                      r_ready,
    input  agen_pkg::uop_ctrl_t       r_ctrl,
    input  agen_pkg::operand_sel_e    r_op0_sel,
    input  agen_pkg::operand_sel_e    r_op1_sel,
    input  agen_pkg::seg_idx_e        r_seg_override,
    input  logic                      r_seg_override_valid,
    input  agen_pkg::gpr_file_t       r_gpr,
    input  agen_pkg::seg_file_t       r_seg,
    input  agen_pkg::mmx_file_t       r_mmx,

    // to memory access
    output logic                      a_valid,
    input  logic                      a_ready,
    output agen_pkg::agen_out_t       a_out
);

    agen_pkg::reg_views_t          views;
    logic [agen_pkg::ADDR_W-1:0]   src_addr;
    logic [agen_pkg::ADDR_W-1:0]   dst_addr;
    logic [agen_pkg::OPND_W-1:0]   op0_val;
    logic [agen_pkg::OPND_W-1:0]   op1_val;
    logic                          op1_is_address;
    logic                          to_sys;
    agen_pkg::agen_out_t           stage_in;

    reg_size_select reg_size_select_i (
        .clk   (clk),
        .size  (r_ctrl.size),
        .gpr   (r_gpr),
        .mmx   (r_mmx),
        .views (views)
    );

    string_addr string_addr_i (
        .clk                (clk),
        .gpr                (r_gpr),
        .seg                (r_seg),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .src_addr           (src_addr),
        .dst_addr           (dst_addr)
    );

    // op0 memory is always ES:EDI
    operand_select op0_select (
        .clk        (clk),
        .sel        (r_op0_sel),
        .reg_idx    (r_ctrl.op0_reg),
        .views      (views),
        .seg        (r_seg),
        .mmx        (r_mmx),
        .imm        (r_ctrl.imm),
        .mem_addr   (dst_addr),
        .operand    (op0_val),
        .is_address ()
    );

    operand_select op1_select (
        .clk        (clk),
        .sel        (r_op1_sel),
        .reg_idx    (r_ctrl.op1_reg),
        .views      (views),
        .seg        (r_seg),
        .mmx        (r_mmx),
        .imm        (r_ctrl.imm),
        .mem_addr   (src_addr),
        .operand    (op1_val),
        .is_address (op1_is_address)
    );

    // op0 code 7 goes to the system controller
    assign to_sys   = (r_op0_sel == agen_pkg::SEL_SYS);
    assign stage_in = {r_ctrl, op0_val, op1_val, op1_is_address, to_sys};

    pipe_stage pipe_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (stage_in),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_out)
    );

endmodule

//--- bench/agen_model.svh
/*
 * Reference model for the address generation testbench. Predicts sized
 * views, string addresses and the full stage output from the x86 rules.
 */

`ifndef AGEN_MODEL_SVH
`define AGEN_MODEL_SVH

// AL..BL low bytes, AH..BH from bits 15:8 of the same four registers
function automatic logic [63:0] sized_view(agen_pkg::size_e size, agen_pkg::gpr_file_t gpr,
                                           agen_pkg::mmx_file_t mmx, int idx);
    case (size)
        agen_pkg::SIZE_BYTE:  return (idx < 4) ? {56'd0, gpr[idx][7:0]} : {56'd0, gpr[idx - 4][15:8]};
        agen_pkg::SIZE_WORD:  return {48'd0, gpr[idx][15:0]};
        agen_pkg::SIZE_DWORD: return {32'd0, gpr[idx]};
        agen_pkg::SIZE_MMX:   return mmx[idx];
        default:              return 64'd0;
    endcase
endfunction

function automatic logic [31:0] seg_base(logic [15:0] sel);
    return {16'd0, sel} * 32'd16;
endfunction

// ES:EDI
function automatic logic [31:0] string_dst(agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg);
    return seg_base(seg[0]) + gpr[7];
endfunction

// DS:ESI unless overridden
function automatic logic [31:0] string_src(agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg,
                                           logic ovv, agen_pkg::seg_idx_e ov);
    logic [15:0] s;
    if (!ovv) begin
        s = seg[3];
    end else if (int'(ov) <= 5) begin
        s = seg[ov];
    end else begin
        s = 16'd0;
    end
    return seg_base(s) + gpr[6];
endfunction

function automatic logic [63:0] pick_operand(agen_pkg::operand_sel_e sel, logic [2:0] idx,
        agen_pkg::size_e size, agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg,
        agen_pkg::mmx_file_t mmx, logic [47:0] imm, logic [31:0] mem);
    case (sel)
        agen_pkg::SEL_REG: return sized_view(size, gpr, mmx, int'(idx));
        agen_pkg::SEL_SEG: return (idx < 3'd6) ? {48'd0, seg[idx]} : 64'd0;
        agen_pkg::SEL_MMX: return mmx[idx];
        agen_pkg::SEL_IMM: return {16'd0, imm};
        agen_pkg::SEL_MEM: return {32'd0, mem};
        default:           return 64'd0;
    endcase
endfunction

function automatic agen_pkg::agen_out_t expect_out(agen_pkg::uop_ctrl_t ctrl,
        agen_pkg::operand_sel_e sel0, agen_pkg::operand_sel_e sel1, logic ovv,
        agen_pkg::seg_idx_e ov, agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg,
        agen_pkg::mmx_file_t mmx);
    agen_pkg::agen_out_t o;
    o.ctrl = ctrl;
    o.op0 = pick_operand(sel0, ctrl.op0_reg, ctrl.size, gpr, seg, mmx, ctrl.imm,
                         string_dst(gpr, seg));
    o.op1 = pick_operand(sel1, ctrl.op1_reg, ctrl.size, gpr, seg, mmx, ctrl.imm,
                         string_src(gpr, seg, ovv, ov));
    o.op1_is_address = (sel1 == agen_pkg::SEL_MEM);
    o.to_sys_controller = (sel0 == agen_pkg::SEL_SYS);
    return o;
endfunction

`endif

//--- bench/agen_tb.sv
/*
 * Testbench for the address generation stage. Offers micro-ops with random
 * register files, predicts each output with the model and checks data and
 * handshake through concurrent assertions against a queue of expected items.
 */

`timescale 1ns/100ps

module agen_tb;

    localparam int WAIT_LIMIT = 64;
    localparam agen_pkg::size_e SIZES [5] = '{agen_pkg::SIZE_NONE, agen_pkg::SIZE_BYTE,
        agen_pkg::SIZE_WORD, agen_pkg::SIZE_DWORD, agen_pkg::SIZE_MMX};
    localparam agen_pkg::operand_sel_e DATA_SELS [4] = '{agen_pkg::SEL_NONE,
        agen_pkg::SEL_SEG, agen_pkg::SEL_MMX, agen_pkg::SEL_IMM};
    // everything but mod r/m
    localparam agen_pkg::operand_sel_e LEGAL_SELS [7] = '{agen_pkg::SEL_NONE,
        agen_pkg::SEL_REG, agen_pkg::SEL_SEG, agen_pkg::SEL_MMX, agen_pkg::SEL_IMM,
        agen_pkg::SEL_MEM, agen_pkg::SEL_SYS};

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    logic                   r_valid;
    logic                   r_ready;
    agen_pkg::uop_ctrl_t    r_ctrl;
    agen_pkg::operand_sel_e r_op0_sel;
    agen_pkg::operand_sel_e r_op1_sel;
    agen_pkg::seg_idx_e     r_seg_override;
    logic                   r_seg_override_valid;
    agen_pkg::gpr_file_t    r_gpr;
    agen_pkg::seg_file_t    r_seg;
    agen_pkg::mmx_file_t    r_mmx;
    logic                   a_valid;
    logic                   a_ready;
    agen_pkg::agen_out_t    a_out;

    agen_pkg::agen_out_t    exp_q [$];
    agen_pkg::agen_out_t    exp_head;
    int                     exp_count;
    int                     errors = 0;
    int                     items_checked = 0;
    int                     tests_run = 0;
    logic                   timed_out;

    `include "agen_model.svh"

    agen_top agen_top_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .flush                (flush),
        .r_valid              (r_valid),
        .r_ready              (r_ready),
        .r_ctrl               (r_ctrl),
        .r_op0_sel            (r_op0_sel),
        .r_op1_sel            (r_op1_sel),
        .r_seg_override       (r_seg_override),
        .r_seg_override_valid (r_seg_override_valid),
        .r_gpr                (r_gpr),
        .r_seg                (r_seg),
        .r_mmx                (r_mmx),
        .a_valid              (a_valid),
        .a_ready              (a_ready),
        .a_out                (a_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected items: pop on output transfer, push on input transfer
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q.delete();
            exp_head <= '0;
            exp_count <= 0;
        end else begin
            if (a_valid && a_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                items_checked++;
            end
            if (flush) begin
                exp_q.delete();
            end else if (r_valid && r_ready) begin
                exp_q.push_back(expect_out(r_ctrl, r_op0_sel, r_op1_sel, r_seg_override_valid,
                                           r_seg_override, r_gpr, r_seg, r_mmx));
            end
            if (exp_q.size() > 0) begin
                exp_head <= exp_q[0];
            end else begin
                exp_head <= '0;
            end
            exp_count <= exp_q.size();
        end
    end

    check_data: assert property (@(posedge clk) disable iff (!rst_n)
        (a_valid && a_ready) |-> (exp_count != 0 && a_out == exp_head))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: a_out %h, expected %h", $time, $sampled(a_out),
                     $sampled(exp_head));
        end

    check_ready: assert property (@(posedge clk) disable iff (!rst_n)
        r_ready == (!a_valid || a_ready))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: r_ready does not follow a_valid and a_ready", $time);
        end

    check_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (a_valid && !a_ready && !flush) |=> (a_valid && $stable(a_out)))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: output moved while stalled", $time);
        end

    check_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !a_valid)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: a_valid high after flush", $time);
        end

    check_reset: assert property (@(posedge clk) !rst_n |-> (!a_valid && r_ready))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: wrong handshake state in reset", $time);
        end

    function automatic agen_pkg::uop_ctrl_t random_ctrl(agen_pkg::size_e size,
                                                        logic [2:0] op0_reg, logic [2:0] op1_reg);
        logic [127:0]        bits;
        agen_pkg::uop_ctrl_t c;
        bits = {$urandom, $urandom, $urandom, $urandom};
        c = bits[$bits(agen_pkg::uop_ctrl_t)-1:0];
        c.size = size;
        c.op0_reg = op0_reg;
        c.op1_reg = op1_reg;
        return c;
    endfunction

    task automatic randomize_regs();
        logic [31:0] rnd;
        for (int i = 0; i < agen_pkg::NUM_REGS; i++) begin
            r_gpr[i] = $urandom;
            r_mmx[i] = {$urandom, $urandom};
        end
        for (int i = 0; i < agen_pkg::NUM_SEG; i++) begin
            rnd = $urandom;
            r_seg[i] = rnd[15:0];
        end
    endtask

    task automatic offer_item(input agen_pkg::uop_ctrl_t ctrl, input agen_pkg::operand_sel_e sel0,
                              input agen_pkg::operand_sel_e sel1, input logic ovv,
                              input agen_pkg::seg_idx_e ov);
        r_ctrl = ctrl;
        r_op0_sel = sel0;
        r_op1_sel = sel1;
        r_seg_override_valid = ovv;
        r_seg_override = ov;
        r_valid = 1'b1;
    endtask

    // r_ready read at the edge still shows the pre-edge state
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!r_ready && !timed_out) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout at %0t: item was never accepted", $time);
            end else begin
                @(posedge clk);
            end
        end
        #2;
        r_valid = 1'b0;
    endtask

    task automatic send_item(input agen_pkg::uop_ctrl_t ctrl, input agen_pkg::operand_sel_e sel0,
                             input agen_pkg::operand_sel_e sel1, input logic ovv,
                             input agen_pkg::seg_idx_e ov);
        offer_item(ctrl, sel0, sel1, ovv, ov);
        wait_accept();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        a_ready = 1'b1;
        @(posedge clk);
        while ((a_valid || exp_count != 0) && !timed_out) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout at %0t: stage did not drain", $time);
            end else begin
                @(posedge clk);
            end
        end
        #2;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (timed_out) begin
            $display("test %s: stopped by timeout", name);
        end else if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_views();
        int err_before;
        err_before = errors;
        for (int s = 0; s < 5; s++) begin
            for (int i = 0; i < agen_pkg::NUM_REGS; i++) begin
                randomize_regs();
                send_item(random_ctrl(SIZES[s], 3'(i), 3'(7 - i)), agen_pkg::SEL_REG,
                          agen_pkg::SEL_REG, 1'b0, agen_pkg::SEG_DS);
            end
        end
        wait_drain();
        finish_test("sized views", err_before);
    endtask

    task automatic test_selections();
        int err_before;
        err_before = errors;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < agen_pkg::NUM_REGS; i++) begin
                randomize_regs();
                send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'(i), 3'(7 - i)), DATA_SELS[s],
                          DATA_SELS[3 - s], 1'b0, agen_pkg::SEG_DS);
            end
        end
        wait_drain();
        finish_test("selections", err_before);
    endtask

    task automatic test_string_addr();
        int err_before;
        err_before = errors;
        randomize_regs();
        send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd0, 3'd0), agen_pkg::SEL_MEM,
                  agen_pkg::SEL_MEM, 1'b0, agen_pkg::SEG_ES);
        for (int o = 0; o < agen_pkg::NUM_SEG; o++) begin
            randomize_regs();
            send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd1, 3'd2), agen_pkg::SEL_MEM,
                      agen_pkg::SEL_MEM, 1'b1, agen_pkg::seg_idx_e'(o));
        end
        // op1 not memory, is-address low
        send_item(random_ctrl(agen_pkg::SIZE_WORD, 3'd3, 3'd4), agen_pkg::SEL_MEM,
                  agen_pkg::SEL_REG, 1'b0, agen_pkg::SEG_ES);
        // both sums carry out of bit 31
        r_seg[0] = 16'hffff;
        r_seg[3] = 16'hf000;
        r_gpr[7] = 32'hffff_ff00;
        r_gpr[6] = 32'hffff_f000;
        send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd5, 3'd6), agen_pkg::SEL_MEM,
                  agen_pkg::SEL_MEM, 1'b0, agen_pkg::SEG_ES);
        wait_drain();
        finish_test("string addresses", err_before);
    endtask

    task automatic test_sys_flag();
        int err_before;
        err_before = errors;
        for (int k = 0; k < 6; k++) begin
            randomize_regs();
            send_item(random_ctrl(SIZES[$urandom_range(0, 4)], 3'($urandom_range(0, 7)),
                                  3'($urandom_range(0, 7))), agen_pkg::SEL_SYS,
                      LEGAL_SELS[$urandom_range(0, 6)], 1'b0, agen_pkg::SEG_ES);
            send_item(random_ctrl(SIZES[$urandom_range(0, 4)], 3'($urandom_range(0, 7)),
                                  3'($urandom_range(0, 7))), LEGAL_SELS[$urandom_range(0, 5)],
                      agen_pkg::SEL_SYS, 1'b0, agen_pkg::SEG_ES);
        end
        wait_drain();
        finish_test("sys flag", err_before);
    endtask

    task automatic test_backpressure();
        int err_before;
        err_before = errors;
        a_ready = 1'b0;
        randomize_regs();
        send_item(random_ctrl(agen_pkg::SIZE_BYTE, 3'd4, 3'd5), agen_pkg::SEL_REG,
                  agen_pkg::SEL_IMM, 1'b0, agen_pkg::SEG_ES);
        offer_item(random_ctrl(agen_pkg::SIZE_MMX, 3'd1, 3'd2), agen_pkg::SEL_MMX,
                   agen_pkg::SEL_MEM, 1'b1, agen_pkg::SEG_FS);
        // stalled for a while with a second item waiting
        repeat (5) @(posedge clk);
        #2;
        a_ready = 1'b1;
        wait_accept();
        send_item(random_ctrl(agen_pkg::SIZE_WORD, 3'd7, 3'd0), agen_pkg::SEL_SEG,
                  agen_pkg::SEL_REG, 1'b0, agen_pkg::SEG_ES);
        wait_drain();
        finish_test("backpressure", err_before);
    endtask

    task automatic test_flush_reset();
        int err_before;
        err_before = errors;
        a_ready = 1'b0;
        send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd2, 3'd3), agen_pkg::SEL_REG,
                  agen_pkg::SEL_REG, 1'b0, agen_pkg::SEG_ES);
        // pending item dropped
        flush = 1'b1;
        @(posedge clk);
        #2;
        a_ready = 1'b1;
        // offered during flush, must not be taken
        offer_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd0, 3'd1), agen_pkg::SEL_IMM,
                   agen_pkg::SEL_IMM, 1'b0, agen_pkg::SEG_ES);
        @(posedge clk);
        #2;
        flush = 1'b0;
        r_valid = 1'b0;
        wait_drain();
        a_ready = 1'b0;
        send_item(random_ctrl(agen_pkg::SIZE_DWORD, 3'd6, 3'd7), agen_pkg::SEL_REG,
                  agen_pkg::SEL_MMX, 1'b0, agen_pkg::SEG_ES);
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        send_item(random_ctrl(agen_pkg::SIZE_BYTE, 3'd5, 3'd4), agen_pkg::SEL_REG,
                  agen_pkg::SEL_MEM, 1'b0, agen_pkg::SEG_ES);
        wait_drain();
        finish_test("flush and reset", err_before);
    endtask

    initial begin
        void'($urandom(32'h343));
        rst_n = 1'b0;
        flush = 1'b0;
        r_valid = 1'b0;
        r_ctrl = '0;
        r_op0_sel = agen_pkg::SEL_NONE;
        r_op1_sel = agen_pkg::SEL_NONE;
        r_seg_override = agen_pkg::SEG_ES;
        r_seg_override_valid = 1'b0;
        r_gpr = '0;
        r_seg = '0;
        r_mmx = '0;
        a_ready = 1'b1;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_views();
        test_selections();
        test_string_addr();
        test_sys_flag();
        test_backpressure();
        test_flush_reset();
        $display("tests %0d, items checked %0d, errors %0d", tests_run, items_checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
logic/agen_pkg.sv
logic/reg_size_select.sv
logic/string_addr.sv
logic/operand_select.sv
logic/pipe_stage.sv
logic/agen_top.sv
bench/agen_tb.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= agen_tb
FILELIST ?= filelist.f
VFLAGS   ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/agen_model.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
